// ==== sim.f ====
rv_pkg.sv
rv_pc_unit.sv
rv_regfile.sv
rv_decoder.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -F -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_rv_core.sv ====
// testbench for the single-cycle RV32I core
// LFSR-built random instructions, checked against an ISA model
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int          N_INSTR        = 3000;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = N_INSTR + RESET_CYCLES + 100;
    localparam logic [15:0] LFSR_SEED      = 16'd6378;

    logic    clk;
    logic    reset;
    word_t   imem_data;
    word_t   imem_addr;
    retire_t retire;

    logic [15:0] lfsr;
    word_t       model_regs [REG_COUNT];  // architectural state of the model
    word_t       model_pc;
    int          cycles = 0;

    rv_core u_rv_core (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .retire    (retire)
    );

    bind rv_core rv_core_chk u_rv_core_chk (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic word_t take_bits(input int n);
        word_t bits;
        logic  fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic is_kept_opcode(input logic [6:0] op);
        case (op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_IMM, OP_REG: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t gen_instruction();
        word_t      inst;
        logic [3:0] cls;
        logic [2:0] f3;
        logic [6:0] op;
        inst = take_bits(32);  // random fields and immediate bits
        cls  = 4'(take_bits(4));
        case (cls)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                inst[6:0]   = OP_REG;
                inst[31:25] = {1'b0, inst[30], 5'b0};  // keep only funct7 bit 5
            end
            4'd6, 4'd7, 4'd8, 4'd9: inst[6:0] = OP_IMM;
            4'd10, 4'd11: begin
                inst[6:0] = OP_BRANCH;
                f3        = 3'(take_bits(3));
                if (f3 == 3'b010) f3 = 3'b000;  // reserved encodings remapped
                if (f3 == 3'b011) f3 = 3'b111;
                inst[14:12] = f3;
                if (take_bits(2) == 0) begin
                    inst[24:20] = inst[19:15];  // equal operands now and then
                end
            end
            4'd12: inst[6:0] = OP_JAL;
            4'd13: begin
                inst[6:0]   = OP_JALR;
                inst[14:12] = 3'b000;
            end
            4'd14: inst[6:0] = (take_bits(1) != 0) ? OP_LUI : OP_AUIPC;
            default: begin
                op = 7'(take_bits(7));
                while (is_kept_opcode(op)) begin
                    op = 7'(take_bits(7));
                end
                inst[6:0] = op;
            end
        endcase
        return inst;
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t x, input word_t y);
        word_t      r;
        logic [4:0] sh;
        sh = y[4:0];  // shifts use 5 bits only
        case (f3)
            3'b000: r = alt ? x - y : x + y;
            3'b001: r = x << sh;
            3'b010: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: r = (x < y) ? 32'd1 : 32'd0;
            3'b100: r = x ^ y;
            3'b101: begin
                if (alt) r = $signed(x) >>> sh;
                else r = x >> sh;
            end
            3'b110: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
        case (f3)
            3'b000: return x == y;
            3'b001: return x != y;
            3'b100: return $signed(x) < $signed(y);
            3'b101: return $signed(x) >= $signed(y);
            3'b110: return x < y;
            3'b111: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // expected retire record for one instruction at the model pc
    function automatic retire_t predict(input word_t inst);
        retire_t    expected;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        logic       wr;
        f3    = inst[14:12];
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        wr    = 1'b0;
        expected.valid   = 1'b1;
        expected.pc      = model_pc;
        expected.inst    = inst;
        expected.illegal = 1'b0;
        expected.rd      = inst[11:7];
        expected.wdata   = '0;
        expected.next_pc = model_pc + 32'd4;
        case (inst[6:0])
            OP_REG: begin
                wr             = 1'b1;
                expected.wdata = alu_model(f3, inst[30], a, b);
            end
            OP_IMM: begin
                wr             = 1'b1;
                expected.wdata = alu_model(f3, (f3 == 3'b101) & inst[30], a, imm_i);
            end
            OP_LUI: begin
                wr             = 1'b1;
                expected.wdata = imm_u;
            end
            OP_AUIPC: begin
                wr             = 1'b1;
                expected.wdata = model_pc + imm_u;
            end
            OP_JAL: begin
                wr               = 1'b1;
                expected.wdata   = model_pc + 32'd4;
                expected.next_pc = model_pc + imm_j;
            end
            OP_JALR: begin
                wr               = 1'b1;
                expected.wdata   = model_pc + 32'd4;
                expected.next_pc = (a + imm_i) & ~32'h1;
            end
            OP_BRANCH: begin
                if (branch_taken(f3, a, b)) expected.next_pc = model_pc + imm_b;
            end
            default: expected.illegal = 1'b1;
        endcase
        expected.we = wr & (inst[11:7] != 5'd0);
        return expected;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t expected);
        compare_word("retire.valid", 32'(got.valid), 32'(expected.valid));
        compare_word("retire.pc", got.pc, expected.pc);
        compare_word("retire.inst", got.inst, expected.inst);
        compare_word("retire.illegal", 32'(got.illegal), 32'(expected.illegal));
        compare_word("retire.we", 32'(got.we), 32'(expected.we));
        compare_word("retire.rd", 32'(got.rd), 32'(expected.rd));
        compare_word("retire.next_pc", got.next_pc, expected.next_pc);
        if (expected.we) begin
            compare_word("retire.wdata", got.wdata, expected.wdata);  // data only matters on a write
        end
    endtask

    task automatic check_pc(input word_t got, input word_t expected);
        compare_word("imem_addr", got, expected);
    endtask

    initial begin
        retire_t expected;
        word_t   inst;
        lfsr      = LFSR_SEED;
        reset     = 1'b1;
        imem_data = 32'h0000_0013;  // addi x0, x0, 0
        model_pc  = RESET_PC;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int n = 0; n < N_INSTR; n++) begin
            inst      = gen_instruction();
            imem_data = inst;
            expected  = predict(inst);
            @(negedge clk);  // settled, edge still ahead
            check_pc(imem_addr, model_pc);
            check_retire(retire, expected);
            @(posedge clk);
            if (expected.we) begin
                model_regs[expected.rd] = expected.wdata;
            end
            model_pc = expected.next_pc;
            #2;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== rv_core_chk.sv ====
// assertion checker for the core top, watches the retire port and fetch address
`timescale 1ns/1ps

module rv_core_chk (
    input logic            clk,
    input logic            reset,
    input rv_pkg::word_t   imem_addr,
    input rv_pkg::retire_t retire
);
    import rv_pkg::*;

    // x0 is never a write target
    a_no_x0_write: assert property (@(posedge clk) retire.we |-> (retire.rd != '0))
        else $error("register write reported with rd equal to x0");

    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !retire.valid)
        else $error("retire valid while reset is high");

    a_reset_pc: assert property (@(posedge clk) reset |=> (imem_addr == RESET_PC))
        else $error("fetch address after reset is not the reset address");

    // fetch follows the next_pc of the instruction that just retired
    a_next_pc: assert property (@(posedge clk) disable iff (reset)
        retire.valid |=> (imem_addr == $past(retire.next_pc)))
        else $error("fetch address differs from the previous next_pc");

endmodule

// ==== rv_core.sv ====
// single-cycle RV32I core top, one instruction fetched and retired per clock
`timescale 1ns/1ps

module rv_core (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::word_t   imem_data,
    output rv_pkg::word_t   imem_addr,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    word_t     snpc;
    decoded_t  dec;
    exec_t     ex;
    word_t     rdata1;
    word_t     rdata2;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    // imem_addr is the current pc
    rv_pc_unit u_pc_unit (
        .clk   (clk),
        .reset (reset),
        .jump  (ex),
        .pc    (imem_addr),
        .snpc  (snpc)
    );

    rv_decoder u_decoder (
        .inst (imem_data),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (we),
        .waddr  (waddr),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute u_execute (
        .dec    (dec),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .pc     (imem_addr),
        .ex     (ex)
    );

    rv_writeback u_writeback (
        .reset  (reset),
        .dec    (dec),
        .ex     (ex),
        .pc     (imem_addr),
        .snpc   (snpc),
        .inst   (imem_data),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .retire (retire)
    );

endmodule

// ==== rv_writeback.sv ====
// result stage, picks write-back data and builds the retire record
`timescale 1ns/1ps

module rv_writeback (
    input  logic              reset,
    input  rv_pkg::decoded_t  dec,
    input  rv_pkg::exec_t     ex,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     snpc,
    input  rv_pkg::word_t     inst,
    output logic              we,
    output rv_pkg::reg_addr_t waddr,
    output rv_pkg::word_t     wdata,
    output rv_pkg::retire_t   retire
);
    import rv_pkg::*;

    logic wr_req;

    always_comb begin
        wr_req = 1'b0;
        wdata  = ex.alu_result;
        case (dec.opcode)
            OP_JAL, OP_JALR: begin
                wr_req = 1'b1;
                wdata  = snpc;  // link address
            end
            OP_REG, OP_IMM, OP_LUI, OP_AUIPC: wr_req = 1'b1;
            default: wr_req = 1'b0;  // branches and illegal opcodes
        endcase
    end

    // x0 and reset gating in one place
    assign we    = wr_req & (dec.rd != '0) & ~reset;
    assign waddr = dec.rd;

    always_comb begin
        retire.valid   = ~reset;
        retire.pc      = pc;
        retire.inst    = inst;
        retire.illegal = dec.illegal;
        retire.we      = we;
        retire.rd      = dec.rd;
        retire.wdata   = wdata;
        retire.next_pc = ex.jump_en ? ex.jump_target : snpc;
    end

endmodule

// ==== rv_execute.sv ====
// execute stage, operand select, ALU, branch compare and jump target
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    input  rv_pkg::word_t    pc,
    output rv_pkg::exec_t    ex
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      result;
    logic [4:0] shamt;
    logic       taken;
    logic       jump;

    // operand A
    always_comb begin
        case (dec.opcode)
            OP_LUI:                       op_a = '0;
            OP_AUIPC, OP_JAL, OP_BRANCH:  op_a = pc;
            default:                      op_a = rdata1;
        endcase
    end

    assign op_b  = (dec.fmt == FMT_R) ? rdata2 : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;  // ALU_ADD
        endcase
    end

    // branch condition always compares rs1 against rs2
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);
            3'b001:  taken = (rdata1 != rdata2);
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  taken = (rdata1 < rdata2);
            3'b111:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;  // reserved encodings fall through
        endcase
    end

    // illegal opcodes land in the default arm, so they never jump
    always_comb begin
        case (dec.opcode)
            OP_JAL, OP_JALR: jump = 1'b1;
            OP_BRANCH:       jump = taken;
            default:         jump = 1'b0;
        endcase
    end

    always_comb begin
        ex.alu_result  = result;
        ex.jump_en     = jump;
        ex.jump_target = result;
        if (dec.opcode == OP_JALR) begin
            ex.jump_target[0] = 1'b0;  // JALR target is halfword aligned
        end
    end

endmodule

// ==== rv_decoder.sv ====
// decode stage, splits the instruction into fields, format, immediate
// and ALU operation
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    opcode_t    opcode;
    inst_fmt_t  fmt;
    alu_op_t    alu_op;
    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm;
    logic       illegal;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // format classification
    always_comb begin
        illegal = 1'b0;
        case (opcode)
            OP_REG:          fmt = FMT_R;
            OP_IMM, OP_JALR: fmt = FMT_I;
            OP_BRANCH:       fmt = FMT_B;
            OP_LUI, OP_AUIPC: fmt = FMT_U;
            OP_JAL:          fmt = FMT_J;
            default: begin
                fmt     = FMT_NONE;
                illegal = 1'b1;  // retires as a no-op
            end
        endcase
    end

    // immediates, sign extended from bit 31
    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'b0};
            FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // ALU op, only arithmetic opcodes use funct3/funct7
    always_comb begin
        alu_op = ALU_ADD;  // address and link arithmetic
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (funct3)
                3'b000: alu_op = (fmt == FMT_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode  = opcode;
        dec.fmt     = fmt;
        dec.alu_op  = alu_op;
        dec.funct3  = funct3;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.imm     = imm;
        dec.illegal = illegal;
    end

endmodule

// ==== rv_regfile.sv ====
// general purpose register file, 32 words, two async reads and one sync write
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [REG_COUNT];

    // x0 is never written, so it holds the reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== rv_pc_unit.sv ====
// program counter, loads the jump target or pc+4 every clock
`timescale 1ns/1ps

module rv_pc_unit (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::exec_t jump,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t snpc
);
    import rv_pkg::*;

    word_t dnpc;

    assign snpc = pc + 32'd4;
    assign dnpc = jump.jump_en ? jump.jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;  // no stalls, always advances
        end
    end

endmodule

// ==== rv_pkg.sv ====
// shared widths, encodings and stage records for the single-cycle RV32I core
// opcode, format and ALU enums plus the packed structs passed between stages
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // base opcodes kept in this core, everything else decodes as illegal
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE    // unknown opcode, no operands
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // decode -> execute / write-back
    typedef struct packed {
        opcode_t   opcode;
        inst_fmt_t fmt;
        alu_op_t   alu_op;
        logic [2:0] funct3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      illegal;
    } decoded_t;

    // execute -> write-back and PC unit
    typedef struct packed {
        word_t alu_result;
        logic  jump_en;
        word_t jump_target;
    } exec_t;

    // one record per retired instruction
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        logic      illegal;
        logic      we;
        reg_addr_t rd;
        word_t     wdata;
        word_t     next_pc;
    } retire_t;

endpackage
